// ==== verilog/exe_pkg.sv ====
// Shared width types, the internal ALU operation enum and pipeline depth constants
package exe_pkg;

    // Operand and result word of one lane
    typedef logic [31:0] word_t;

    // Destination register number
    typedef logic [4:0] reg_num_t;

    // Immediate field as sent by the host, sign-extended in decode
    typedef logic [11:0] imm_t;

    // Opcode field as sent by the host
    typedef logic [2:0] opcode_t;

    // Wrapping count of retired instructions
    typedef logic [15:0] retire_count_t;

    // Internal operations, in the same order as the host opcodes
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_sll,
        op_srl,
        op_mul
    } alu_op_t;

    // Number of execute stages, set by the two-stage multiplier
    localparam int mul_depth = 2;

    // Issue to writeback in cycles when nothing stalls
    // One decode stage, the execute stages and one commit stage
    localparam int exe_latency = mul_depth + 2;

endpackage

// ==== verilog/pipe_register.sv ====
// Parameterized pipe register with shared enable, partial reset and configurable depth
`timescale 1ns/1ps

module pipe_register #(
    parameter int data_width  = 1,
    parameter int reset_width = 0,
    parameter int depth       = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  enable,
    input  logic [data_width-1:0] data_in,
    output logic [data_width-1:0] data_out
);

    if (depth == 0) begin : g_wire
        assign data_out = data_in;
    end else if (depth == 1) begin : g_single
        if (reset_width == 0) begin : g_no_reset
            logic [data_width-1:0] value;

            always_ff @(posedge clk) begin
                if (enable) begin
                    value <= data_in;
                end
            end
            assign data_out = value;
        end else if (reset_width == data_width) begin : g_full_reset
            logic [data_width-1:0] value;

            always_ff @(posedge clk) begin
                if (reset) begin
                    value <= '0;
                end else if (enable) begin
                    value <= data_in;
                end
            end
            assign data_out = value;
        end else begin : g_split_reset
            // Only the control bits at the top are cleared, the payload below is not
            logic [reset_width-1:0]            value_r;
            logic [data_width-reset_width-1:0] value_d;

            always_ff @(posedge clk) begin
                if (reset) begin
                    value_r <= '0;
                end else if (enable) begin
                    value_r <= data_in[data_width-1:data_width-reset_width];
                end
            end

            always_ff @(posedge clk) begin
                if (enable) begin
                    value_d <= data_in[data_width-reset_width-1:0];
                end
            end
            assign data_out = {value_r, value_d};
        end
    end else begin : g_chain
        logic [depth:0][data_width-1:0] chain;

        assign chain[0] = data_in;
        for (genvar i = 1; i <= depth; i++) begin : g_stage
            pipe_register #(
                .data_width  (data_width),
                .reset_width (reset_width),
                .depth       (1)
            ) stage_reg (
                .clk      (clk),
                .reset    (reset),
                .enable   (enable),
                .data_in  (chain[i-1]),
                .data_out (chain[i])
            );
        end
        assign data_out = chain[depth];
    end

endmodule

// ==== verilog/exe_bus_if.sv ====
// Decoded instruction bundle between the decode and execute stages
`timescale 1ns/1ps

interface exe_bus_if;
    import exe_pkg::*;

    logic     valid;
    alu_op_t  op;
    reg_num_t rd;
    word_t    a;
    // Second operand, already replaced by the immediate where selected
    word_t    b;

    modport src (
        output valid,
        output op,
        output rd,
        output a,
        output b
    );

    modport dst (
        input valid,
        input op,
        input rd,
        input a,
        input b
    );

endinterface

// ==== verilog/exe_decode.sv ====
// Decode stage: opcode mapping, immediate select and the decode pipe register
`timescale 1ns/1ps

module exe_decode (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              in_valid,
    input  exe_pkg::opcode_t  in_opcode,
    input  exe_pkg::reg_num_t in_rd,
    input  exe_pkg::word_t    in_a,
    input  exe_pkg::word_t    in_b,
    input  exe_pkg::imm_t     in_imm,
    input  logic              in_imm_sel,
    exe_bus_if.src            dec
);
    import exe_pkg::*;

    alu_op_t op;
    word_t   b_sel;

    // Valid bit on top, then op, rd, a and b
    logic [2*$bits(word_t)+$bits(reg_num_t)+$bits(alu_op_t):0] dec_d;
    logic [2*$bits(word_t)+$bits(reg_num_t)+$bits(alu_op_t):0] dec_q;
    logic [$bits(alu_op_t)-1:0] op_bits;

    always_comb begin
        case (in_opcode)
            3'd0: op = op_add;
            3'd1: op = op_sub;
            3'd2: op = op_and;
            3'd3: op = op_or;
            3'd4: op = op_xor;
            3'd5: op = op_sll;
            3'd6: op = op_srl;
            default: op = op_mul;
        endcase
    end

    // The immediate is signed, so its top bit fills the upper word
    assign b_sel = in_imm_sel ? {{($bits(word_t)-$bits(imm_t)){in_imm[$bits(imm_t)-1]}}, in_imm}
                              : in_b;

    assign dec_d = {in_valid, op, in_rd, in_a, b_sel};

    pipe_register #(
        .data_width  ($bits(dec_d)),
        .reset_width (1),
        .depth       (1)
    ) dec_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (dec_d),
        .data_out (dec_q)
    );

    assign {dec.valid, op_bits, dec.rd, dec.a, dec.b} = dec_q;
    assign dec.op = alu_op_t'(op_bits);

endmodule

// ==== verilog/exe_alu.sv ====
// Execute stages: single-cycle operations, two-stage multiplier and the result delay chain
`timescale 1ns/1ps

module exe_alu (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    exe_bus_if.dst             dec,
    output logic               res_valid,
    output exe_pkg::reg_num_t  res_rd,
    output exe_pkg::word_t     res_data
);
    import exe_pkg::*;

    word_t alu_result;
    logic  is_mul;

    // Multiplier partial products and their sum
    word_t pp_lo;
    word_t pp_hi;
    word_t pp_lo_q;
    word_t pp_hi_q;
    word_t mul_sum;
    word_t mul_q;

    // Delay chain word: valid, multiply select, rd and the early result
    logic [$bits(reg_num_t)+$bits(word_t)+1:0] pad_d;
    logic [$bits(reg_num_t)+$bits(word_t)+1:0] pad_q;
    logic  mul_sel;
    word_t pad_result;

    always_comb begin
        case (dec.op)
            op_add:  alu_result = dec.a + dec.b;
            op_sub:  alu_result = dec.a - dec.b;
            op_and:  alu_result = dec.a & dec.b;
            op_or:   alu_result = dec.a | dec.b;
            op_xor:  alu_result = dec.a ^ dec.b;
            op_sll:  alu_result = dec.a << dec.b[4:0];
            op_srl:  alu_result = dec.a >> dec.b[4:0];
            default: alu_result = '0;
        endcase
    end

    assign is_mul = (dec.op == op_mul);

    // Only the low word of the product is kept, so each partial is cut to 32 bits
    assign pp_lo = dec.a * {16'b0, dec.b[15:0]};
    assign pp_hi = dec.a * {16'b0, dec.b[31:16]};

    pipe_register #(
        .data_width  (2 * $bits(word_t)),
        .reset_width (0),
        .depth       (1)
    ) pp_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({pp_lo, pp_hi}),
        .data_out ({pp_lo_q, pp_hi_q})
    );

    assign mul_sum = pp_lo_q + (pp_hi_q << 16);

    // The sum fills the remaining execute stages
    pipe_register #(
        .data_width  ($bits(word_t)),
        .reset_width (0),
        .depth       (mul_depth - 1)
    ) mul_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (mul_sum),
        .data_out (mul_q)
    );

    assign pad_d = {dec.valid, is_mul, dec.rd, alu_result};

    pipe_register #(
        .data_width  ($bits(pad_d)),
        .reset_width (1),
        .depth       (mul_depth)
    ) pad_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  (pad_d),
        .data_out (pad_q)
    );

    assign {res_valid, mul_sel, res_rd, pad_result} = pad_q;

    assign res_data = mul_sel ? mul_q : pad_result;

endmodule

// ==== verilog/exe_commit.sv ====
// Commit stage: register-0 write filter, writeback register and retirement counter
`timescale 1ns/1ps

module exe_commit (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   res_valid,
    input  exe_pkg::reg_num_t      res_rd,
    input  exe_pkg::word_t         res_data,
    output logic                   wb_valid,
    output exe_pkg::reg_num_t      wb_rd,
    output exe_pkg::word_t         wb_data,
    output exe_pkg::retire_count_t retire_count
);
    import exe_pkg::*;

    logic          write_en;
    retire_count_t count;

    // Register 0 is hardwired, so its writes never reach the host
    assign write_en = res_valid && (res_rd != '0);

    pipe_register #(
        .data_width  (1 + $bits(reg_num_t) + $bits(word_t)),
        .reset_width (1),
        .depth       (1)
    ) wb_reg (
        .clk      (clk),
        .reset    (reset),
        .enable   (enable),
        .data_in  ({write_en, res_rd, res_data}),
        .data_out ({wb_valid, wb_rd, wb_data})
    );

    // Every valid result retires, dropped register-0 writes included
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (enable && res_valid) begin
            count <= count + 1'b1;
        end
    end

    assign retire_count = count;

endmodule

// ==== verilog/exe_top.sv ====
// Top level of the execute pipeline: stage instances and the stall-to-enable inversion
`timescale 1ns/1ps

module exe_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  exe_pkg::opcode_t       in_opcode,
    input  exe_pkg::reg_num_t      in_rd,
    input  exe_pkg::word_t         in_a,
    input  exe_pkg::word_t         in_b,
    input  exe_pkg::imm_t          in_imm,
    input  logic                   in_imm_sel,
    input  logic                   stall,
    output logic                   wb_valid,
    output exe_pkg::reg_num_t      wb_rd,
    output exe_pkg::word_t         wb_data,
    output exe_pkg::retire_count_t retire_count
);
    import exe_pkg::*;

    logic     enable;
    logic     res_valid;
    reg_num_t res_rd;
    word_t    res_data;

    // One global stall freezes all stages together
    assign enable = ~stall;

    exe_bus_if dec_bus ();

    exe_decode decode (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .in_valid   (in_valid),
        .in_opcode  (in_opcode),
        .in_rd      (in_rd),
        .in_a       (in_a),
        .in_b       (in_b),
        .in_imm     (in_imm),
        .in_imm_sel (in_imm_sel),
        .dec        (dec_bus.src)
    );

    exe_alu alu (
        .clk       (clk),
        .reset     (reset),
        .enable    (enable),
        .dec       (dec_bus.dst),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data)
    );

    exe_commit commit (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .res_valid    (res_valid),
        .res_rd       (res_rd),
        .res_data     (res_data),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_count (retire_count)
    );

endmodule

// ==== bench/tb_clock.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 100,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2.0) clk = ~clk;
    end

    // Reset is released on a rising edge, after the DUT has seen it for reset_cycles edges
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== bench/tb_exe_top.sv ====
// Testbench for the execute pipeline: stimulus reader, driver, writeback checker and watchdog
`timescale 1ns/1ps

module tb_exe_top;
    import exe_pkg::*;

    localparam int period_ns    = 100;
    localparam int reset_cycles = 4;
    localparam int max_lines    = 256;

    logic          clk;
    logic          reset;
    logic          in_valid;
    opcode_t       in_opcode;
    reg_num_t      in_rd;
    word_t         in_a;
    word_t         in_b;
    imm_t          in_imm;
    logic          in_imm_sel;
    logic          stall;
    logic          wb_valid;
    reg_num_t      wb_rd;
    word_t         wb_data;
    retire_count_t retire_count;

    // Stimulus table with one entry per data line of the file
    logic     st_valid    [max_lines];
    opcode_t  st_opcode   [max_lines];
    reg_num_t st_rd       [max_lines];
    word_t    st_a        [max_lines];
    word_t    st_b        [max_lines];
    imm_t     st_imm      [max_lines];
    logic     st_imm_sel  [max_lines];
    logic     st_stall    [max_lines];
    word_t    st_expected [max_lines];
    int       line_count;
    logic     stimulus_loaded = 1'b0;

    // Results still in flight, in issue order, with the unstalled edge count at issue
    reg_num_t exp_rd   [$];
    word_t    exp_data [$];
    int       exp_mark [$];

    word_t cur_expected;
    int    run_edges;
    int    issued_count;
    int    check_count;
    int    error_count;

    tb_clock #(
        .period_ns    (period_ns),
        .reset_cycles (reset_cycles)
    ) clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    exe_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_opcode    (in_opcode),
        .in_rd        (in_rd),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_imm       (in_imm),
        .in_imm_sel   (in_imm_sel),
        .stall        (stall),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .retire_count (retire_count)
    );

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        word_t v_valid;
        word_t v_op;
        word_t v_rd;
        word_t v_a;
        word_t v_b;
        word_t v_imm;
        word_t v_sel;
        word_t v_stall;
        word_t v_exp;

        line_count = 0;
        fd = $fopen("bench/exe_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file bench/exe_stimulus.txt");
            error_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Lines starting with a hash are comments
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_valid, v_op, v_rd,
                            v_a, v_b, v_imm, v_sel, v_stall, v_exp);
                if (n != 9) begin
                    $display("Stimulus line could not be parsed: %s", line);
                    error_count++;
                end else if (line_count >= max_lines) begin
                    $display("Stimulus file holds more than %0d lines", max_lines);
                    error_count++;
                end else begin
                    st_valid[line_count]    = v_valid[0];
                    st_opcode[line_count]   = v_op[2:0];
                    st_rd[line_count]       = v_rd[4:0];
                    st_a[line_count]        = v_a;
                    st_b[line_count]        = v_b;
                    st_imm[line_count]      = v_imm[11:0];
                    st_imm_sel[line_count]  = v_sel[0];
                    st_stall[line_count]    = v_stall[0];
                    st_expected[line_count] = v_exp;
                    line_count++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Called at a rising edge: checks what the DUT presented, then drives the next line
    task automatic step_edge(input int idx);
        reg_num_t rd_exp;
        word_t    data_exp;
        int       mark;

        if (wb_valid && !stall) begin
            if (exp_rd.size() == 0) begin
                $display("Writeback to register %0d arrived with no instruction pending", wb_rd);
                error_count++;
            end else begin
                rd_exp   = exp_rd.pop_front();
                data_exp = exp_data.pop_front();
                mark     = exp_mark.pop_front();
                check_count++;
                if (wb_rd !== rd_exp) begin
                    $display("ERROR wb_rd: got %h, expected %h", wb_rd, rd_exp);
                    error_count++;
                end
                if (wb_data !== data_exp) begin
                    $display("ERROR wb_data: got %h, expected %h", wb_data, data_exp);
                    error_count++;
                end
                if (run_edges - mark != exe_latency) begin
                    $display("Result for register %0d arrived %0d unstalled cycles after issue",
                             rd_exp, run_edges - mark);
                    error_count++;
                end
            end
        end

        // An instruction is accepted on this edge when it is valid and not stalled
        if (in_valid && !stall) begin
            issued_count++;
            if (in_rd != '0) begin
                exp_rd.push_back(in_rd);
                exp_data.push_back(cur_expected);
                exp_mark.push_back(run_edges);
            end
        end
        if (!stall) begin
            run_edges++;
        end

        if (idx >= 0) begin
            in_valid     <= st_valid[idx];
            in_opcode    <= st_opcode[idx];
            in_rd        <= st_rd[idx];
            in_a         <= st_a[idx];
            in_b         <= st_b[idx];
            in_imm       <= st_imm[idx];
            in_imm_sel   <= st_imm_sel[idx];
            stall        <= st_stall[idx];
            cur_expected <= st_expected[idx];
        end else begin
            in_valid <= 1'b0;
            stall    <= 1'b0;
        end
    endtask

    initial begin : main
        in_valid     = 1'b0;
        in_opcode    = '0;
        in_rd        = '0;
        in_a         = '0;
        in_b         = '0;
        in_imm       = '0;
        in_imm_sel   = 1'b0;
        stall        = 1'b0;
        cur_expected = '0;
        run_edges    = 0;
        issued_count = 0;
        check_count  = 0;
        error_count  = 0;

        read_stimulus();
        stimulus_loaded = 1'b1;

        @(posedge clk);
        while (reset) begin
            @(posedge clk);
        end

        // Nothing has been issued yet
        check_count++;
        if (wb_valid !== 1'b0) begin
            $display("ERROR wb_valid: got %h, expected 0 after reset", wb_valid);
            error_count++;
        end
        if (retire_count !== '0) begin
            $display("ERROR retire_count: got %h, expected 0000 after reset", retire_count);
            error_count++;
        end

        for (int i = 0; i < line_count; i++) begin
            step_edge(i);
            @(posedge clk);
        end
        while (exp_rd.size() > 0) begin
            step_edge(-1);
            @(posedge clk);
        end
        // A few idle cycles catch stray writebacks and let register-0 writes retire
        repeat (exe_latency + 1) begin
            step_edge(-1);
            @(posedge clk);
        end

        check_count++;
        if (retire_count !== issued_count[15:0]) begin
            $display("ERROR retire_count: got %h, expected %h", retire_count, issued_count[15:0]);
            error_count++;
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (stimulus_loaded);
        #((line_count + exe_latency + 20) * period_ns);
        $display("Timeout: the run did not finish within %0d clock periods",
                 line_count + exe_latency + 20);
        $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== bench/exe_stimulus.txt ====
# valid opcode rd a b imm imm_sel stall expected, all in hex
# opcodes 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 mul
# each operation back to back, register operands
1 0 01 00000005 00000003 000 0 0 00000008
1 0 02 ffffffff 00000002 000 0 0 00000001
1 1 03 00000010 00000001 000 0 0 0000000f
1 1 04 00000000 00000001 000 0 0 ffffffff
1 2 05 f0f0f0f0 ff00ff00 000 0 0 f000f000
1 3 06 12340000 00005678 000 0 0 12345678
1 4 07 aaaaaaaa ffff0000 000 0 0 5555aaaa
1 5 08 00000001 0000001f 000 0 0 80000000
1 5 09 00000003 00000024 000 0 0 00000030
1 6 0a 80000000 0000001f 000 0 0 00000001
1 6 0b f0000000 00000004 000 0 0 0f000000
1 6 0c 12345678 00000020 000 0 0 12345678
1 7 0d 00000007 00000006 000 0 0 0000002a
1 7 0e 00010000 00010000 000 0 0 00000000
1 7 0f 12345678 00000010 000 0 0 23456780
1 7 10 ffffffff ffffffff 000 0 0 00000001
1 7 11 0000ffff 0000ffff 000 0 0 fffe0001
1 7 12 00012345 00000100 000 0 0 01234500
# immediate replaces b, positive and negative
1 0 13 00000100 deadbeef 005 1 0 00000105
1 0 14 00000100 deadbeef fff 1 0 000000ff
1 1 15 00000010 deadbeef ff0 1 0 00000020
1 2 16 12345678 deadbeef 800 1 0 12345000
1 3 17 00000000 deadbeef 7ff 1 0 000007ff
1 4 18 0000ffff deadbeef fff 1 0 ffff0000
1 5 19 00000001 deadbeef 008 1 0 00000100
1 6 1a 80000000 deadbeef 01f 1 0 00000001
1 7 1b 00000003 deadbeef ffe 1 0 fffffffa
1 7 1c 00001000 deadbeef 123 1 0 00123000
# writes to register 0 retire without a writeback
1 0 00 00000001 00000001 000 0 0 00000002
1 7 00 00000002 00000003 000 0 0 00000006
# stalls in the middle of the stream
1 0 1d 00000001 00000002 000 0 0 00000003
1 7 1e 00000005 00000005 000 0 0 00000019
0 0 00 00000000 00000000 000 0 1 00000000
0 0 00 00000000 00000000 000 0 1 00000000
1 4 1f 0000000f 000000f0 000 0 0 000000ff
1 1 01 00000064 00000014 000 0 1 00000050
1 1 01 00000064 00000014 000 0 0 00000050
1 5 02 0000000f 00000010 000 0 0 000f0000
0 0 00 00000000 00000000 000 0 1 00000000
1 7 03 00000100 00000100 000 0 0 00010000
1 6 04 00010000 00000008 000 0 0 00000100
0 0 00 00000000 00000000 000 0 1 00000000
0 0 00 00000000 00000000 000 0 1 00000000
0 0 00 00000000 00000000 000 0 1 00000000
1 2 05 0000ffff 00ff00ff 000 0 0 000000ff
1 3 06 0f000000 000000f0 000 0 0 0f0000f0
0 0 00 00000000 00000000 000 0 0 00000000
1 0 00 0000000a 0000000b 000 0 0 00000015
0 0 00 00000000 00000000 000 0 1 00000000
1 7 07 00000400 00000400 000 0 0 00100000
1 0 08 7fffffff 00000001 000 0 0 80000000
1 7 09 00020000 00008000 000 0 0 00000000
1 1 0a 00000000 deadbeef 001 1 0 ffffffff
0 0 00 00000000 00000000 000 0 1 00000000

// ==== sources.f ====
verilog/exe_pkg.sv
verilog/pipe_register.sv
verilog/exe_bus_if.sv
verilog/exe_decode.sv
verilog/exe_alu.sv
verilog/exe_commit.sv
verilog/exe_top.sv
bench/tb_clock.sv
bench/tb_exe_top.sv
